// File: common/sifhPkg.sv
// SiFH shared definitions
package sifhPkg;

    // ********************************************************************
    // Sizes
    // ********************************************************************
    localparam int TIME_W    = 12;               // Timestamp width in ticks
    localparam int COARSE_W  = 6;                // Coarse bin index, also fine bin width
    localparam int HALF_WIN  = 32;               // Half search window
    localparam int WIN_SIZE  = 2 * HALF_WIN;     // 64 ticks, one fine histogram
    localparam int PIXEL_NUM = 4;                // Pixels served in turn
    localparam int DATA_NUM  = 4;                // Samples per pixel visit
    localparam int ACQ_NUM   = 8;                // Acquisitions per pass
    localparam int BIN_NUM   = 2 ** COARSE_W;    // Bins per pixel histogram
    localparam int COUNT_W   = 6;                // Holds 32 hits per pixel and pass

    // Counter widths
    localparam int PIX_W  = $clog2(PIXEL_NUM);
    localparam int DATA_W = $clog2(DATA_NUM);
    localparam int ACQ_W  = $clog2(ACQ_NUM);

    // Highest lower edge, window then ends one tick below full scale
    localparam int LOW_MAX = (2 ** TIME_W - 1) - WIN_SIZE;    // 4031

    // ********************************************************************
    // Types
    // ********************************************************************
    typedef logic [TIME_W-1:0]   timeT;     // Timestamp
    typedef logic [COARSE_W-1:0] binT;      // Bin index
    typedef logic [PIX_W-1:0]    pixT;      // Pixel index
    typedef logic [COUNT_W-1:0]  countT;    // Bin count

    // Pass of a frame
    typedef enum logic {
        COARSE = 1'b0,    // Top bits pick the bin
        FINE   = 1'b1     // Full resolution inside the window
    } passT;

    // One timestamp per pixel, pixel 0 in the low bits
    typedef logic [PIXEL_NUM*TIME_W-1:0] peakVecT;

endpackage

// File: rtl/frameSequencer.sv
// Frame and pass sequencer
`timescale 1ns/100ps

module frameSequencer import sifhPkg::*; (
    input  logic clk,
    input  logic combin_res,
    input  logic sampleValid,
    output passT pass,
    output pixT  pixel,
    output logic passEnd,
    output passT endedPass
);

    logic [DATA_W-1:0] dataCnt;    // Sample within pixel visit
    pixT               pixCnt;     // Current pixel
    logic [ACQ_W-1:0]  acqCnt;     // Acquisition within pass
    logic              lastData;
    logic              lastPix;
    logic              lastSample;
    logic              endDly;     // First delay stage of the pass end

    assign lastData   = (dataCnt == DATA_W'(DATA_NUM - 1));
    assign lastPix    = (pixCnt == PIX_W'(PIXEL_NUM - 1));
    assign lastSample = sampleValid && lastData && lastPix && (acqCnt == ACQ_W'(ACQ_NUM - 1));

    assign pixel = pixCnt;    // Owner of the sample in this cycle

    // ********************************************************************
    // Sample, pixel and acquisition counters
    // ********************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            dataCnt <= '0;
            pixCnt  <= '0;
            acqCnt  <= '0;
        end else if (sampleValid) begin
            dataCnt <= dataCnt + 1'b1;             // Wraps at DATA_NUM
            if (lastData) begin
                pixCnt <= pixCnt + 1'b1;           // Next pixel
                if (lastPix) begin
                    acqCnt <= acqCnt + 1'b1;       // Wraps at end of pass
                end
            end
        end
    end

    // ********************************************************************
    // Pass tracking and pass end delay
    // ********************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pass      <= COARSE;
            endedPass <= COARSE;
            endDly    <= 1'b0;
            passEnd   <= 1'b0;
        end else begin
            if (lastSample) begin
                pass      <= (pass == COARSE) ? FINE : COARSE;
                endedPass <= pass;                 // Held until passEnd is used
            end
            endDly  <= lastSample;
            passEnd <= endDly;    // Last peak update has settled by now
        end
    end

endmodule

// File: rtl/sampleFilter.sv
// Sample to bin index filter
`timescale 1ns/100ps

module sampleFilter import sifhPkg::*; (
    input  logic    sampleValid,
    input  timeT    sample,
    input  passT    pass,
    input  pixT     pixel,
    input  peakVecT winLow,
    output logic    binValid,
    output binT     binIdx
);

    timeT lowEdge;    // Window start of the current pixel
    timeT highEdge;   // First tick past the window
    binT  offset;     // Distance from the lower edge
    logic inWin;

    always_comb begin
        lowEdge  = winLow[pixel*TIME_W +: TIME_W];
        highEdge = lowEdge + timeT'(WIN_SIZE);    // Ends at full scale at most
        offset   = binT'(sample - lowEdge);
        inWin    = (sample >= lowEdge) && (sample < highEdge);
    end

    // ********************************************************************
    // Bin selection per pass
    // ********************************************************************
    always_comb begin
        if (pass == COARSE) begin
            binIdx   = sample[TIME_W-1 -: COARSE_W];    // Top bits only
            binValid = sampleValid;
        end else begin
            binIdx   = offset;                          // Relative to window start
            binValid = sampleValid && inWin;            // Outside window dropped
        end
    end

endmodule

// File: histogram/binMemory.sv
// Histogram bin counters
`timescale 1ns/100ps

module binMemory import sifhPkg::*; (
    input  logic  clk,
    input  logic  combin_res,
    input  logic  binValid,
    input  binT   binIdx,
    input  pixT   pixel,
    input  logic  clear,
    output logic  histValid,
    output pixT   histPixel,
    output binT   histBin,
    output countT histCount
);

    countT                          mem [PIXEL_NUM*BIN_NUM];    // One counter per pixel and bin
    logic  [PIXEL_NUM*BIN_NUM-1:0]  filled;         // Bin holds a count of this pass
    logic  [PIX_W+COARSE_W-1:0]     addr;
    countT                          newCount;

    // Invalid bin reads as zero, so a hit starts at one
    always_comb begin
        addr     = {pixel, binIdx};
        newCount = filled[addr] ? mem[addr] + 1'b1 : countT'(1);
    end

    // ********************************************************************
    // Valid flags, cleared in one cycle
    // ********************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            filled    <= '0;
            histValid <= 1'b0;
        end else begin
            if (clear) begin
                filled <= '0;               // Whole histogram empty at once
            end else if (binValid) begin
                filled[addr] <= 1'b1;
            end
            histValid <= binValid && !clear;
        end
    end

    // Counter write and result of the update
    always_ff @(posedge clk) begin
        if (binValid) begin
            mem[addr] <= newCount;          // Next hit sees this value
        end
        histPixel <= pixel;
        histBin   <= binIdx;
        histCount <= newCount;
    end

endmodule

// File: histogram/peakTracker.sv
// Running peak per pixel
`timescale 1ns/100ps

module peakTracker import sifhPkg::*; (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          histValid,
    input  pixT                           histPixel,
    input  binT                           histBin,
    input  countT                         histCount,
    input  logic                          clear,
    output logic [PIXEL_NUM*COARSE_W-1:0] peakBins
);

    countT maxCount [PIXEL_NUM];    // Largest count so far
    binT   maxBin   [PIXEL_NUM];    // Bin that reached it first
    logic  better;

    // Strictly greater, a tie keeps the earlier bin
    assign better = histValid && (histCount > maxCount[histPixel]);

    // ********************************************************************
    // Maximum update
    // ********************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                maxCount[p] <= '0;
                maxBin[p]   <= '0;
            end
        end else if (clear) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                maxCount[p] <= '0;    // Empty pixel reports bin 0
                maxBin[p]   <= '0;
            end
        end else if (better) begin
            maxCount[histPixel] <= histCount;
            maxBin[histPixel]   <= histBin;
        end
    end

    // Flatten, pixel 0 in the low bits
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            peakBins[p*COARSE_W +: COARSE_W] = maxBin[p];
        end
    end

endmodule

// File: rtl/windowUnit.sv
// Search window and peak time unit
`timescale 1ns/100ps

module windowUnit import sifhPkg::*; (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          passEnd,
    input  passT                          endedPass,
    input  logic [PIXEL_NUM*COARSE_W-1:0] peakBins,
    output peakVecT                       winLow,
    output peakVecT                       peakTime,
    output logic                          frameDone
);

    peakVecT nextLow;     // Clamped lower edges from the coarse peaks
    peakVecT nextPeak;    // Lower edge plus fine peak bin
    timeT    centre;
    binT     bin;

    // ********************************************************************
    // Window and result arithmetic
    // ********************************************************************
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            bin    = peakBins[p*COARSE_W +: COARSE_W];
            centre = timeT'(bin) << (TIME_W - COARSE_W);    // Coarse bin start
            if (centre <= timeT'(HALF_WIN)) begin
                nextLow[p*TIME_W +: TIME_W] = '0;                 // Clamp at zero
            end else if (centre >= timeT'(LOW_MAX)) begin
                nextLow[p*TIME_W +: TIME_W] = timeT'(LOW_MAX);    // Clamp at top
            end else begin
                nextLow[p*TIME_W +: TIME_W] = centre - timeT'(HALF_WIN);
            end
            nextPeak[p*TIME_W +: TIME_W] = winLow[p*TIME_W +: TIME_W] + timeT'(bin);
        end
    end

    // ********************************************************************
    // Latches at pass end
    // ********************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winLow    <= '0;
            peakTime  <= '0;
            frameDone <= 1'b0;
        end else begin
            if (passEnd && (endedPass == COARSE)) begin
                winLow <= nextLow;        // Used by the fine pass
            end
            if (passEnd && (endedPass == FINE)) begin
                peakTime <= nextPeak;     // Stable until next frame
            end
            frameDone <= passEnd && (endedPass == FINE);
        end
    end

endmodule

// File: rtl/sifhTop.sv
// SiFH peak finder top level
`timescale 1ns/100ps

module sifhTop import sifhPkg::*; (
    input  logic    clk,
    input  logic    combin_res,
    input  logic    sampleValid,
    input  timeT    sample,
    output peakVecT peakTime,
    output logic    frameDone
);

    passT                          pass;
    pixT                           pixel;
    logic                          passEnd;
    passT                          endedPass;
    logic                          binValid;
    binT                           binIdx;
    logic                          histValid;
    pixT                           histPixel;
    binT                           histBin;
    countT                         histCount;
    logic [PIXEL_NUM*COARSE_W-1:0] peakBins;
    peakVecT                       winLow;

    // ********************************************************************
    // Control and input side
    // ********************************************************************
    frameSequencer i_frameSequencer (
        .clk, .combin_res, .sampleValid,
        .pass, .pixel, .passEnd, .endedPass
    );

    sampleFilter i_sampleFilter (
        .sampleValid, .sample, .pass, .pixel, .winLow,
        .binValid, .binIdx
    );

    // ********************************************************************
    // Histogram and peak
    // ********************************************************************
    binMemory i_binMemory (
        .clk, .combin_res, .binValid, .binIdx, .pixel,
        .clear (passEnd),    // Empty for the next pass
        .histValid, .histPixel, .histBin, .histCount
    );

    peakTracker i_peakTracker (
        .clk, .combin_res, .histValid, .histPixel, .histBin, .histCount,
        .clear (passEnd),
        .peakBins
    );

    windowUnit i_windowUnit (
        .clk, .combin_res, .passEnd, .endedPass, .peakBins,
        .winLow, .peakTime, .frameDone
    );

endmodule

// File: tb/sifhChecks.svh
// SiFH reference model and checks
`ifndef SIFH_CHECKS_SVH
`define SIFH_CHECKS_SVH

localparam int PASS_LEN = DATA_NUM * PIXEL_NUM * ACQ_NUM;    // Samples per pass
typedef timeT passArrT [PASS_LEN];                         // One pass, in arrival order

// ********************************************************************
// Reference peak times for one stored frame
// ********************************************************************
function automatic peakVecT expectedPeaks(input passArrT coarse, input passArrT fine);
    int      hist   [PIXEL_NUM][BIN_NUM];
    int      maxCnt [PIXEL_NUM];
    int      maxBin [PIXEL_NUM];
    int      low    [PIXEL_NUM];
    int      pix;
    int      b;
    int      t;
    int      centre;
    peakVecT result;
    result = '0;
    for (int ps = 0; ps < 2; ps++) begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            maxCnt[p] = 0;
            maxBin[p] = 0;      // Empty histogram reports bin 0
            for (int i = 0; i < BIN_NUM; i++) hist[p][i] = 0;
        end
        for (int k = 0; k < PASS_LEN; k++) begin
            pix = (k / DATA_NUM) % PIXEL_NUM;
            if (ps == 0) begin
                b = int'(coarse[k]) >> (TIME_W - COARSE_W);    // Top bits
            end else begin
                t = int'(fine[k]) - low[pix];
                b = (t >= 0 && t < 2 * HALF_WIN) ? t : -1;     // Outside window dropped
            end
            if (b >= 0) begin
                hist[pix][b]++;
                if (hist[pix][b] > maxCnt[pix]) begin          // Tie keeps first bin
                    maxCnt[pix] = hist[pix][b];
                    maxBin[pix] = b;
                end
            end
        end
        if (ps == 0) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                centre = maxBin[p] * (2 ** (TIME_W - COARSE_W));
                if (centre <= HALF_WIN) low[p] = 0;
                else if (centre > 2 ** TIME_W - 2 - 2 * HALF_WIN) low[p] = 4031;
                else low[p] = centre - HALF_WIN;
            end
        end
    end
    for (int p = 0; p < PIXEL_NUM; p++) begin
        result[p*TIME_W +: TIME_W] = timeT'(low[p] + maxBin[p]);
    end
    return result;
endfunction

// ********************************************************************
// Compare tasks
// ********************************************************************
task automatic checkPeakTime(input string name, input timeT got, input timeT exp);
    if (got !== exp) failRun($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

// A strobe is only legal when allowed
task automatic checkStrobe(input string name, input logic got, input logic allowed);
    if (got === 1'b1 && allowed !== 1'b1) begin
        failRun($sformatf("Mismatch %s: got 0x%0h expected 0x0", name, got));
    end
endtask

task automatic checkLatency(input string name, input int got, input int exp);
    if (got != exp) failRun($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

`endif

// File: tb/sifhTb.sv
// SiFH peak finder testbench
`timescale 1ns/100ps

module sifhTb import sifhPkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYC    = 16;
    localparam int GAP_CYC      = 8;                        // Idle cycles after each pass
    localparam int DONE_LAT     = 3;                        // Last fine sample to frameDone
    localparam int RAND_FRAMES  = 6;
    localparam int FRAME_NUM    = 4 + RAND_FRAMES + 2;      // Cut frame included
    localparam int MODE_CLUSTER = 0;
    localparam int MODE_CLAMP   = 1;
    localparam int MODE_OUTSIDE = 2;
    localparam int MODE_TIE     = 3;
    localparam int MODE_RANDOM  = 4;

    logic    clk = 1'b0;
    logic    combin_res;
    logic    sampleValid;
    timeT    sample;
    peakVecT peakTime;
    logic    frameDone;

    sifhTop i_dut (.clk, .combin_res, .sampleValid, .sample, .peakTime, .frameDone);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "sifhChecks.svh"

    localparam int WATCHDOG_NS = FRAME_NUM * 2 * PASS_LEN * 4 * CLK_PERIOD + 2000;

    passArrT coarseArr;
    passArrT fineArr;
    peakVecT expPeaks       = '0;
    int      cycleCnt       = 0;    // Rising edges so far
    int      lastFineCycle  = 0;
    int      framesFinished = 0;    // Frames whose last fine sample went out
    int      checkedFrames  = 0;

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // Cluster sample with half of them exactly on target
    function automatic timeT nearValue(input int tgt);
        return timeT'(tgt + (($urandom % 2 == 0) ? 0 : int'($urandom % 7)));
    endfunction

    // ********************************************************************
    // Frame stimulus
    // ********************************************************************
    task automatic makeFrame(input int mode);
        int tgt [PIXEL_NUM];
        int pix;
        int j;
        int hiBin;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (mode == MODE_CLAMP) tgt[p] = (p < 2) ? 3 + 14 * p : 4040 + 45 * (p - 2);
            else if (mode == MODE_RANDOM) tgt[p] = int'($urandom % 4096);
            else tgt[p] = (10 + 13 * p) * 64 + 5 + 6 * p;    // Near a coarse bin start
        end
        for (int k = 0; k < PASS_LEN; k++) begin
            pix   = (k / DATA_NUM) % PIXEL_NUM;
            j     = (k / (DATA_NUM * PIXEL_NUM)) * DATA_NUM + k % DATA_NUM;    // Nth of pixel
            hiBin = (40 + pix) * 64;
            case (mode)
                MODE_OUTSIDE: begin
                    coarseArr[k] = nearValue(tgt[pix]);
                    fineArr[k]   = timeT'((j < 12) ? tgt[pix] : tgt[pix] + 200);    // Big far cluster
                end
                MODE_TIE: begin        // Alternating bins where the first one wins
                    coarseArr[k] = timeT'((j % 2 == 0) ? hiBin + 5 : (20 + pix) * 64 + 5);
                    fineArr[k]   = timeT'((j % 2 == 0) ? hiBin + 10 : hiBin - 10);
                end
                MODE_RANDOM: begin
                    coarseArr[k] = ($urandom % 2 == 0) ? nearValue(tgt[pix]) : timeT'($urandom);
                    fineArr[k]   = ($urandom % 2 == 0) ? nearValue(tgt[pix]) : timeT'($urandom);
                end
                default: begin
                    coarseArr[k] = nearValue(tgt[pix]);
                    fineArr[k]   = nearValue(tgt[pix]);
                end
            endcase
        end
    endtask

    // Starts and ends on a falling edge with the strobe low
    task automatic sendPass(input passArrT arr, input int count, input bit endsFrame);
        int idle;
        for (int k = 0; k < count; k++) begin
            idle = int'($urandom % 3);
            repeat (idle) @(negedge clk);
            sampleValid = 1'b1;
            sample      = arr[k];
            if (endsFrame && k == count - 1) begin
                lastFineCycle  = cycleCnt;
                framesFinished = framesFinished + 1;
            end
            @(negedge clk);
            sampleValid = 1'b0;
        end
    endtask

    task automatic waitFrameDone(input int target);
        for (int i = 0; i < 2 * DONE_LAT + 2; i++) begin
            @(posedge clk);
            if (checkedFrames >= target) break;
        end
        if (checkedFrames < target) failRun($sformatf("No frameDone seen for frame %0d", target));
        @(negedge clk);
    endtask

    task automatic sendFrame();
        expPeaks = expectedPeaks(coarseArr, fineArr);
        sendPass(coarseArr, PASS_LEN, 1'b0);
        repeat (GAP_CYC) @(negedge clk);
        sendPass(fineArr, PASS_LEN, 1'b1);
        waitFrameDone(framesFinished);
        repeat (GAP_CYC) @(negedge clk);
    endtask

    task automatic checkResetState();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            checkPeakTime($sformatf("peakTime[%0d]", p), peakTime[p*TIME_W +: TIME_W], timeT'(0));
        end
        checkStrobe("frameDone", frameDone, 1'b0);
    endtask

    // ********************************************************************
    // Main sequence
    // ********************************************************************
    initial begin
        void'($urandom(12));
        combin_res  = 1'b0;
        sampleValid = 1'b0;
        sample      = '0;
        repeat (RESET_CYC) @(negedge clk);
        combin_res = 1'b1;
        repeat (4) @(negedge clk);
        makeFrame(MODE_CLUSTER);
        sendFrame();
        makeFrame(MODE_CLAMP);
        sendFrame();
        makeFrame(MODE_OUTSIDE);
        sendFrame();
        makeFrame(MODE_TIE);
        sendFrame();
        repeat (RAND_FRAMES) begin    // Back to back so the histograms must clear
            makeFrame(MODE_RANDOM);
            sendFrame();
        end
        makeFrame(MODE_RANDOM);       // Cut by reset halfway through the fine pass
        sendPass(coarseArr, PASS_LEN, 1'b0);
        repeat (GAP_CYC) @(negedge clk);
        sendPass(fineArr, PASS_LEN / 2, 1'b0);
        combin_res = 1'b0;
        repeat (RESET_CYC) begin
            @(negedge clk);
            checkResetState();
        end
        combin_res = 1'b1;
        repeat (4) begin
            @(negedge clk);
            checkResetState();
        end
        makeFrame(MODE_RANDOM);
        sendFrame();
        if (checkedFrames == framesFinished && checkedFrames == FRAME_NUM - 1) begin
            $display("Simulation passed");
            $finish;
        end else begin
            failRun($sformatf("Only %0d of %0d frames checked", checkedFrames, FRAME_NUM - 1));
        end
    end

    // Compare on every frameDone
    always @(negedge clk) begin
        if (frameDone) begin
            checkStrobe("frameDone", frameDone, framesFinished > checkedFrames);
            checkLatency("frameDone latency", cycleCnt - lastFineCycle, DONE_LAT);
            for (int p = 0; p < PIXEL_NUM; p++) begin
                checkPeakTime($sformatf("peakTime[%0d]", p), peakTime[p*TIME_W +: TIME_W],
                              expPeaks[p*TIME_W +: TIME_W]);
            end
            checkedFrames = checkedFrames + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        failRun($sformatf("Watchdog expired after %0d ns without finishing", WATCHDOG_NS));
    end

endmodule

// File: filelist.f
common/sifhPkg.sv
rtl/frameSequencer.sv
rtl/sampleFilter.sv
histogram/binMemory.sv
histogram/peakTracker.sv
rtl/windowUnit.sv
rtl/sifhTop.sv
+incdir+tb
tb/sifhTb.sv

// File: Makefile
# Verilator flow for the SiFH peak finder

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= sifhTb
RTL_TOP   ?= sifhTop
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "No result found in $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
